// File: attack_area.sv
`timescale 1ns/1ps

module attack_area #(
    parameter int ATTACK_SHORT = 16,
    parameter int ATTACK_LONG  = 80
) (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  game_pkg::coord_t       attack_x,
    input  game_pkg::coord_t       attack_y,
    input  game_pkg::direction_t   direction,
    input  logic                   attack_on,
    output game_pkg::attack_rect_t rect
);
    import game_pkg::*;

    localparam int               EXT_W     = $bits(coord_t) + 2;
    localparam logic [EXT_W-1:0] COORD_MAX = EXT_W'((1 << $bits(coord_t)) - 1);

    coord_t x_lo_d;
    coord_t x_hi_d;
    coord_t y_lo_d;
    coord_t y_hi_d;
    coord_t x_lo_q;
    coord_t x_hi_q;
    coord_t y_lo_q;
    coord_t y_hi_q;
    logic   hit_q;

    // Far edge of the window, held at the screen border
    function automatic coord_t reach_up(coord_t base, int len);
        logic [EXT_W-1:0] sum;
        sum = EXT_W'(base) + EXT_W'(len);
        return (sum > COORD_MAX) ? coord_t'(COORD_MAX) : coord_t'(sum);
    endfunction

    function automatic coord_t reach_down(coord_t base, int len);
        return (int'(base) < len) ? '0 : coord_t'(int'(base) - len);
    endfunction

    always_comb begin
        x_lo_d = attack_x;
        x_hi_d = reach_up(attack_x, ATTACK_SHORT);
        y_lo_d = attack_y;
        y_hi_d = reach_up(attack_y, ATTACK_SHORT);
        case (direction)
            DIR_DOWN:  y_hi_d = reach_up(attack_y, ATTACK_LONG);
            DIR_LEFT: begin
                x_lo_d = reach_down(attack_x, ATTACK_LONG);
                x_hi_d = attack_x;
            end
            DIR_UP: begin
                y_lo_d = reach_down(attack_y, ATTACK_LONG);
                y_hi_d = attack_y;
            end
            default:   x_hi_d = reach_up(attack_x, ATTACK_LONG);
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= attack_on;
        end
    end

    // Window bounds only matter while hit_q is high
    always_ff @(posedge Clk) begin
        x_lo_q <= x_lo_d;
        x_hi_q <= x_hi_d;
        y_lo_q <= y_lo_d;
        y_hi_q <= y_hi_d;
    end

    assign rect = '{hit: hit_q, x_lo: x_lo_q, x_hi: x_hi_q, y_lo: y_lo_q, y_hi: y_hi_q};

endmodule

// File: combat.f
game_pkg.sv
frame_tick.sv
attack_area.sv
enemy_unit.sv
enemy_status.sv
combat_top.sv
combat_assert.sv
combat_tb.sv

// File: combat_assert.sv
`timescale 1ns/1ps

module combat_assert #(
    parameter int ENEMY_NUM = 4
) (
    input logic                                   Clk,
    input logic                                   rst_n,
    input logic                                   attack_on,
    input logic                                   rect_hit,
    input game_pkg::enemy_state_t [ENEMY_NUM-1:0] enemy_state,
    input logic                   [ENEMY_NUM-1:0] alive_mask,
    input game_pkg::kill_count_t                  kill_count
);
    import game_pkg::*;

    logic                 on_d1;
    logic [ENEMY_NUM-1:0] mask_d1;
    logic [ENEMY_NUM-1:0] mask_d2;
    kill_count_t          count_d1;
    logic                 health_ok;

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            on_d1    <= 1'b0;
            mask_d1  <= '1;
            mask_d2  <= '1;
            count_d1 <= '0;
        end else begin
            on_d1    <= attack_on;
            mask_d1  <= alive_mask;
            mask_d2  <= mask_d1;
            count_d1 <= kill_count;
        end
    end

    always_comb begin
        health_ok = 1'b1;
        for (int i = 0; i < ENEMY_NUM; i++) begin
            if (enemy_state[i].health > HEALTH_FULL) begin
                health_ok = 1'b0;
            end
        end
    end

    // Every hit cycle needs its own pulse one cycle earlier
    hit_from_pulse: assert property (@(posedge Clk) disable iff (!rst_n) rect_hit |-> on_d1)
        else $error("rect.hit high without a pulse on the previous cycle");

    health_bound: assert property (@(posedge Clk) disable iff (!rst_n) health_ok)
        else $error("enemy health above full");

    kill_after_fall: assert property (@(posedge Clk) disable iff (!rst_n)
        (kill_count != count_d1) |-> |(mask_d2 & ~mask_d1))
        else $error("kill_count changed with no alive bit falling");

endmodule

bind combat_top combat_assert #(
    .ENEMY_NUM(ENEMY_NUM)
) combat_assert_i (
    .Clk        (Clk),
    .rst_n      (rst_n),
    .attack_on  (attack_on),
    .rect_hit   (rect.hit),
    .enemy_state(enemy_state),
    .alive_mask (alive_mask),
    .kill_count (kill_count)
);

// File: combat_tb.sv
`timescale 1ns/1ps

module combat_tb;
    import game_pkg::*;

    localparam int NUM       = 4;
    localparam int FRAME_DIV = 2;
    localparam int RESPAWN   = 3;
    localparam int DAMAGE    = 25;
    localparam int SHORT     = 16;
    localparam int LONG      = 80;
    localparam int EW        = 26;
    localparam int EH        = 26;

    logic                     Clk = 1'b0;
    logic                     rst_n;
    logic                     frame_clk;
    coord_t                   attack_x;
    coord_t                   attack_y;
    direction_t               direction;
    logic                     attack_on;
    enemy_pos_t   [NUM-1:0]   enemy_pos;
    enemy_state_t [NUM-1:0]   enemy_state;
    logic         [NUM-1:0]   alive_mask;
    kill_count_t              kill_count;

    // Reference model state
    int          mdl_health[NUM];
    int          mdl_cnt[NUM];
    int          mdl_x[NUM];
    int          mdl_y[NUM];
    kill_count_t mdl_kills;
    int          frame_phase;
    logic [15:0] lfsr_q;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;
    int          guard;

    combat_top #(
        .ENEMY_NUM    (NUM),
        .FRAME_DIV    (FRAME_DIV),
        .RESPAWN_TICKS(RESPAWN)
    ) combat_top_i (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_clk  (frame_clk),
        .attack_x   (attack_x),
        .attack_y   (attack_y),
        .direction  (direction),
        .attack_on  (attack_on),
        .enemy_pos  (enemy_pos),
        .enemy_state(enemy_state),
        .alive_mask (alive_mask),
        .kill_count (kill_count)
    );

    always #10 Clk = ~Clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    function automatic int clamp(int v);
        if (v < 0) begin
            return 0;
        end
        return (v > 511) ? 511 : v;
    endfunction

    // Window from the facing rules, then closed box intersection
    function automatic bit model_hit(int idx, int ax, int ay, direction_t dir);
        int xl;
        int xh;
        int yl;
        int yh;
        xl = ax;
        xh = ax + SHORT;
        yl = ay;
        yh = ay + SHORT;
        case (dir)
            DIR_DOWN:  yh = ay + LONG;
            DIR_LEFT: begin
                xl = ax - LONG;
                xh = ax;
            end
            DIR_UP: begin
                yl = ay - LONG;
                yh = ay;
            end
            default:   xh = ax + LONG;
        endcase
        return (mdl_x[idx] <= clamp(xh)) && (mdl_x[idx] + EW >= clamp(xl)) &&
               (mdl_y[idx] <= clamp(yh)) && (mdl_y[idx] + EH >= clamp(yl));
    endfunction

    task automatic check_state(string name, enemy_state_t got, enemy_state_t expected);
        checks++;
        if (got !== expected) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_mask(string name, logic [NUM-1:0] got, logic [NUM-1:0] expected);
        checks++;
        if (got !== expected) begin
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_count(string name, kill_count_t got, kill_count_t expected);
        checks++;
        if (got !== expected) begin
            $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_all();
        enemy_state_t   expected;
        logic [NUM-1:0] exp_mask;
        for (int i = 0; i < NUM; i++) begin
            expected.alive  = (mdl_health[i] != 0);
            expected.health = health_t'(mdl_health[i]);
            exp_mask[i]     = expected.alive;
            check_state($sformatf("enemy_state[%0d]", i), enemy_state[i], expected);
        end
        check_mask("alive_mask", alive_mask, exp_mask);
        check_count("kill_count", kill_count, mdl_kills);
    endtask

    task automatic apply_reset();
        attack_on = 1'b0;
        frame_clk = 1'b0;
        rst_n     = 1'b0;
        for (int i = 0; i < NUM; i++) begin
            mdl_health[i] = 100;
            mdl_cnt[i]    = 0;
        end
        mdl_kills   = '0;
        frame_phase = 0;
        repeat (8) @(negedge Clk);
        rst_n = 1'b1;
        @(negedge Clk);
    endtask

    task automatic set_enemy(int idx, int x, int y);
        mdl_x[idx]     = x;
        mdl_y[idx]     = y;
        enemy_pos[idx] = '{x: coord_t'(x), y: coord_t'(y)};
    endtask

    // Drives one pulse on the current falling edge and updates the model
    task automatic drive_attack(int ax, int ay, direction_t dir);
        attack_x  = coord_t'(ax);
        attack_y  = coord_t'(ay);
        direction = dir;
        attack_on = 1'b1;
        for (int i = 0; i < NUM; i++) begin
            if (mdl_health[i] > 0 && model_hit(i, ax, ay, dir)) begin
                mdl_health[i] = (mdl_health[i] > DAMAGE) ? mdl_health[i] - DAMAGE : 0;
                if (mdl_health[i] == 0) begin
                    mdl_kills = mdl_kills + 8'd1;
                end
            end
        end
    endtask

    task automatic single_attack(int ax, int ay, direction_t dir);
        drive_attack(ax, ay, dir);
        @(negedge Clk);
        attack_on = 1'b0;
        repeat (2) @(negedge Clk);
        check_all();
    endtask

    // One full frame clock period, long enough for the synchronizer
    task automatic frame_edge();
        frame_clk = 1'b1;
        repeat (8) @(negedge Clk);
        frame_clk = 1'b0;
        repeat (8) @(negedge Clk);
        frame_phase++;
        if (frame_phase == FRAME_DIV) begin
            frame_phase = 0;
            for (int i = 0; i < NUM; i++) begin
                if (mdl_health[i] == 0) begin
                    if (mdl_cnt[i] == RESPAWN) begin
                        mdl_health[i] = 100;
                        mdl_cnt[i]    = 0;
                    end else begin
                        mdl_cnt[i]++;
                    end
                end
            end
        end
        check_all();
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    initial begin
        int ax;
        int ay;
        direction_t dir;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        err_mark  = 0;
        lfsr_q    = 16'd44979;
        rst_n     = 1'b0;
        frame_clk = 1'b0;
        attack_x  = '0;
        attack_y  = '0;
        direction = DIR_DOWN;
        attack_on = 1'b0;
        enemy_pos = '0;
        for (int i = 0; i < NUM; i++) begin
            set_enemy(i, 60 * i, 40 * i);
        end

        apply_reset();
        check_all();
        finish_test("reset state");

        apply_reset();
        for (int n = 0; n < 24; n++) begin
            ax  = rand_bits(9);
            ay  = rand_bits(9);
            dir = direction_t'(2'(rand_bits(2)));
            for (int i = 0; i < NUM; i++) begin
                set_enemy(i, (ax + rand_bits(7) - 64) & 511, (ay + rand_bits(7) - 64) & 511);
            end
            single_attack(ax, ay, dir);
        end
        finish_test("random attacks");

        // Windows that run past the screen border
        apply_reset();
        set_enemy(0, 0, 0);
        set_enemy(1, 490, 490);
        set_enemy(2, 100, 300);
        set_enemy(3, 480, 0);
        single_attack(5, 5, DIR_LEFT);
        single_attack(10, 10, DIR_UP);
        single_attack(505, 505, DIR_RIGHT);
        single_attack(500, 500, DIR_DOWN);
        single_attack(505, 8, DIR_RIGHT);
        single_attack(500, 20, DIR_UP);
        finish_test("clamped window");

        apply_reset();
        set_enemy(0, 200, 200);
        set_enemy(1, 200, 200);
        set_enemy(2, 400, 40);
        set_enemy(3, 40, 400);
        repeat (4) single_attack(200, 200, DIR_DOWN);
        set_enemy(2, 200, 200);
        repeat (4) single_attack(200, 200, DIR_DOWN);
        check_count("kill_count", kill_count, 8'd3);
        finish_test("deaths and kills");

        apply_reset();
        set_enemy(0, 200, 200);
        set_enemy(1, 400, 40);
        set_enemy(2, 40, 400);
        set_enemy(3, 450, 450);
        repeat (6) single_attack(200, 200, DIR_DOWN);
        guard = 0;
        while (mdl_health[0] == 0 && guard < 4 * (RESPAWN + 2) * FRAME_DIV) begin
            frame_edge();
            guard++;
        end
        if (mdl_health[0] == 0) begin
            $display("Enemy 0 was still dead when the frame edge limit ran out");
            errors++;
        end
        check_state("enemy_state[0]", enemy_state[0], '{alive: 1'b1, health: HEALTH_FULL});
        finish_test("respawn");

        // Back to back pulses, one hit each
        apply_reset();
        set_enemy(0, 200, 200);
        set_enemy(1, 210, 220);
        set_enemy(2, 300, 300);
        set_enemy(3, 0, 0);
        drive_attack(200, 200, DIR_DOWN);
        @(negedge Clk);
        drive_attack(300, 290, DIR_DOWN);
        @(negedge Clk);
        drive_attack(195, 210, DIR_RIGHT);
        @(negedge Clk);
        attack_on = 1'b0;
        repeat (2) @(negedge Clk);
        check_all();
        finish_test("consecutive pulses");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #1000000;
        $display("Simulation timed out before all tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: combat_top.sv
`timescale 1ns/1ps

module combat_top #(
    parameter int ENEMY_NUM     = 4,
    parameter int FRAME_DIV     = 4,
    parameter int RESPAWN_TICKS = 200,
    parameter int DAMAGE        = 25,
    parameter int ATTACK_SHORT  = 16,
    parameter int ATTACK_LONG   = 80,
    parameter int ENEMY_W       = 26,
    parameter int ENEMY_H       = 26
) (
    input  logic                                   Clk,
    input  logic                                   rst_n,
    input  logic                                   frame_clk,
    input  game_pkg::coord_t                       attack_x,
    input  game_pkg::coord_t                       attack_y,
    input  game_pkg::direction_t                   direction,
    input  logic                                   attack_on,
    input  game_pkg::enemy_pos_t   [ENEMY_NUM-1:0] enemy_pos,
    output game_pkg::enemy_state_t [ENEMY_NUM-1:0] enemy_state,
    output logic                   [ENEMY_NUM-1:0] alive_mask,
    output game_pkg::kill_count_t                  kill_count
);
    import game_pkg::*;

    logic         game_tick;
    attack_rect_t rect;

    frame_tick #(
        .FRAME_DIV(FRAME_DIV)
    ) frame_tick_i (
        .Clk      (Clk),
        .rst_n    (rst_n),
        .frame_clk(frame_clk),
        .game_tick(game_tick)
    );

    // Window is built once and shared by all enemies
    attack_area #(
        .ATTACK_SHORT(ATTACK_SHORT),
        .ATTACK_LONG (ATTACK_LONG)
    ) attack_area_i (
        .Clk      (Clk),
        .rst_n    (rst_n),
        .attack_x (attack_x),
        .attack_y (attack_y),
        .direction(direction),
        .attack_on(attack_on),
        .rect     (rect)
    );

    for (genvar i = 0; i < ENEMY_NUM; i++) begin : g_enemy
        enemy_unit #(
            .ENEMY_W      (ENEMY_W),
            .ENEMY_H      (ENEMY_H),
            .DAMAGE       (DAMAGE),
            .RESPAWN_TICKS(RESPAWN_TICKS)
        ) enemy_unit_i (
            .Clk      (Clk),
            .rst_n    (rst_n),
            .game_tick(game_tick),
            .rect     (rect),
            .pos      (enemy_pos[i]),
            .state    (enemy_state[i])
        );
    end

    enemy_status #(
        .ENEMY_NUM(ENEMY_NUM)
    ) enemy_status_i (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .state     (enemy_state),
        .alive_mask(alive_mask),
        .kill_count(kill_count)
    );

endmodule

// File: enemy_status.sv
`timescale 1ns/1ps

module enemy_status #(
    parameter int ENEMY_NUM = 4
) (
    input  logic                                   Clk,
    input  logic                                   rst_n,
    input  game_pkg::enemy_state_t [ENEMY_NUM-1:0] state,
    output logic                   [ENEMY_NUM-1:0] alive_mask,
    output game_pkg::kill_count_t                  kill_count
);
    import game_pkg::*;

    localparam int FALL_W = $clog2(ENEMY_NUM + 1);

    logic [ENEMY_NUM-1:0] prev_mask;
    logic [ENEMY_NUM-1:0] fell;
    logic [FALL_W-1:0]    fall_cnt;

    always_comb begin
        for (int i = 0; i < ENEMY_NUM; i++) begin
            alive_mask[i] = state[i].alive;
        end
    end

    // Enemies that died since the last cycle, several may die at once
    assign fell = prev_mask & ~alive_mask;

    always_comb begin
        fall_cnt = '0;
        for (int i = 0; i < ENEMY_NUM; i++) begin
            fall_cnt = fall_cnt + FALL_W'(fell[i]);
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_mask  <= '1;
            kill_count <= '0;
        end else begin
            prev_mask  <= alive_mask;
            kill_count <= kill_count + kill_count_t'(fall_cnt);
        end
    end

endmodule

// File: enemy_unit.sv
`timescale 1ns/1ps

module enemy_unit #(
    parameter int ENEMY_W       = 26,
    parameter int ENEMY_H       = 26,
    parameter int DAMAGE        = 25,
    parameter int RESPAWN_TICKS = 200
) (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  logic                   game_tick,
    input  game_pkg::attack_rect_t rect,
    input  game_pkg::enemy_pos_t   pos,
    output game_pkg::enemy_state_t state
);
    import game_pkg::*;

    localparam int CNT_W = (RESPAWN_TICKS > 0) ? $clog2(RESPAWN_TICKS + 1) : 1;
    localparam int EXT_W = $bits(coord_t) + 2;

    logic [EXT_W-1:0] box_x_lo;
    logic [EXT_W-1:0] box_x_hi;
    logic [EXT_W-1:0] box_y_lo;
    logic [EXT_W-1:0] box_y_hi;
    logic             overlap_x;
    logic             overlap_y;
    logic             struck;
    logic             alive;
    health_t          health;
    health_t          health_d;
    logic [CNT_W-1:0] respawn_cnt;
    logic [CNT_W-1:0] respawn_cnt_d;

    // Closed bounding box, widened so the far edge cannot wrap
    assign box_x_lo = EXT_W'(pos.x);
    assign box_x_hi = EXT_W'(pos.x) + EXT_W'(ENEMY_W);
    assign box_y_lo = EXT_W'(pos.y);
    assign box_y_hi = EXT_W'(pos.y) + EXT_W'(ENEMY_H);

    assign overlap_x = (box_x_lo <= EXT_W'(rect.x_hi)) && (box_x_hi >= EXT_W'(rect.x_lo));
    assign overlap_y = (box_y_lo <= EXT_W'(rect.y_hi)) && (box_y_hi >= EXT_W'(rect.y_lo));
    assign struck    = rect.hit && overlap_x && overlap_y;

    assign alive = (health != '0);

    always_comb begin
        health_d      = health;
        respawn_cnt_d = respawn_cnt;
        if (!alive) begin
            // Dead: wait out the respawn time, hits have no effect
            if (game_tick) begin
                if (respawn_cnt == CNT_W'(RESPAWN_TICKS)) begin
                    health_d      = HEALTH_FULL;
                    respawn_cnt_d = '0;
                end else begin
                    respawn_cnt_d = respawn_cnt + 1'b1;
                end
            end
        end else if (struck) begin
            if (health > health_t'(DAMAGE)) begin
                health_d = health - health_t'(DAMAGE);
            end else begin
                health_d = '0;
            end
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            health      <= HEALTH_FULL;
            respawn_cnt <= '0;
        end else begin
            health      <= health_d;
            respawn_cnt <= respawn_cnt_d;
        end
    end

    assign state = '{alive: alive, health: health};

endmodule

// File: frame_tick.sv
`timescale 1ns/1ps

module frame_tick #(
    parameter int FRAME_DIV = 4
) (
    input  logic Clk,
    input  logic rst_n,
    input  logic frame_clk,
    output logic game_tick
);

    localparam int CNT_W = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

    logic             sync_1;
    logic             sync_2;
    logic             sync_3;
    logic             frame_rise;
    logic [CNT_W-1:0] edge_cnt;

    // Two-flop synchronizer, then one more stage for edge detection
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_1     <= 1'b0;
            sync_2     <= 1'b0;
            sync_3     <= 1'b0;
            frame_rise <= 1'b0;
        end else begin
            sync_1     <= frame_clk;
            sync_2     <= sync_1;
            sync_3     <= sync_2;
            frame_rise <= sync_2 & ~sync_3;
        end
    end

    // One game tick per FRAME_DIV frame edges
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_cnt  <= '0;
            game_tick <= 1'b0;
        end else begin
            game_tick <= 1'b0;
            if (frame_rise) begin
                if (edge_cnt == CNT_W'(FRAME_DIV - 1)) begin
                    edge_cnt  <= '0;
                    game_tick <= 1'b1;
                end else begin
                    edge_cnt <= edge_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: game_pkg.sv
package game_pkg;

    // Screen coordinate, 0 to 511 on both axes
    typedef logic [8:0] coord_t;

    typedef logic [6:0] health_t;

    localparam health_t HEALTH_FULL = health_t'(100);

    // Facing direction of the player
    typedef enum logic [1:0] {
        DIR_DOWN  = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_UP    = 2'd2,
        DIR_RIGHT = 2'd3
    } direction_t;

    // Attack window, valid for one cycle while hit is high
    typedef struct packed {
        logic   hit;
        coord_t x_lo;
        coord_t x_hi;
        coord_t y_lo;
        coord_t y_hi;
    } attack_rect_t;

    // Top-left corner of an enemy bounding box
    typedef struct packed {
        coord_t x;
        coord_t y;
    } enemy_pos_t;

    typedef struct packed {
        logic    alive;
        health_t health;
    } enemy_state_t;

    typedef logic [7:0] kill_count_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the combat testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module combat_tb \
    -f combat.f \
    -o sim_combat
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_combat > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
